// File: verilog/r24_stream_pkg.sv
package r24_stream_pkg;

    //////////////////////////////////////////////////
    // Bus structs
    //////////////////////////////////////////////////

    // APB request from the bus master with pready always high
    typedef struct packed {
        logic [31:0] paddr;
        logic        psel;
        logic        penable;
        logic        pwrite;
        logic [31:0] pwdata;
    } apb_req_t;

    // One FT601 bus word
    typedef struct packed {
        logic [31:0] data;
        logic [3:0]  be;    // Byte enable bit 0 covers data[7:0]
    } usb_word_t;

    typedef logic [7:0] adc_sample_t;   // Channel A sample

    //////////////////////////////////////////////////
    // USB stream source select
    //////////////////////////////////////////////////

    // Code 3 is not named and behaves as idle
    typedef enum logic [1:0] {
        SRC_REG   = 2'd0,   // Software word per data write
        SRC_IDLE  = 2'd1,   // Nothing sent
        SRC_ADC_A = 2'd2    // One ADC sample per cycle
    } wr_src_e;

    //////////////////////////////////////////////////
    // Register page
    //////////////////////////////////////////////////

    localparam logic [19:0] REGS_PAGE = 20'h43C04;    // paddr[31:12]

    localparam logic [11:0] REG_WR_DATA = 12'h000;  // Write pushes a word
    localparam logic [11:0] REG_WR_BE   = 12'h004;  // Byte enables for register words
    localparam logic [11:0] REG_WR_MUX  = 12'h008;  // Source mode
    localparam logic [11:0] REG_LED0    = 12'h00C;
    localparam logic [11:0] REG_LED1    = 12'h010;
    localparam logic [11:0] REG_STATUS  = 12'h014;  // Write clears drop flag

endpackage

// File: verilog/led_ddac.sv
module led_ddac #(
    parameter int LED_DEPTH = 16
) (
    input  logic                 clk,
    input  logic                 arst_n_i,
    input  logic [LED_DEPTH-1:0] level_i,   // Brightness out of 2^LED_DEPTH
    output logic                 pulse_o
);

    logic [LED_DEPTH-1:0] acc_q;
    logic                 carry_q;

    // First-order delta-sigma with the carry as the pulse
    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            acc_q   <= '0;
            carry_q <= 1'b0;
        end else begin
            {carry_q, acc_q} <= {1'b0, acc_q} + {1'b0, level_i};
        end
    end

    assign pulse_o = carry_q;

endmodule

// File: verilog/ft601_tx.sv
module ft601_tx import r24_stream_pkg::*; (
    input  logic        clk,
    input  logic        arst_n_i,
    input  logic        usb_txe_n_i,  // Low when the bridge can take a word
    input  usb_word_t   head_i,
    input  logic        empty_i,
    output logic        pop_o,
    output logic [31:0] usb_d_o,
    output logic [3:0]  usb_be_o,
    output logic        usb_wr_n_o
);

    // Take the head whenever both sides are ready
    assign pop_o = !empty_i && !usb_txe_n_i;

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            usb_d_o    <= '0;
            usb_be_o   <= '0;
            usb_wr_n_o <= 1'b1;   // Bus idle
        end else begin
            usb_wr_n_o <= !pop_o; // Low for the popped word only
            if (pop_o) begin
                usb_d_o  <= head_i.data;
                usb_be_o <= head_i.be;
            end
        end
    end

endmodule

// File: verilog/usb_word_fifo.sv
module usb_word_fifo import r24_stream_pkg::*; #(
    parameter int FIFO_AW = 3
) (
    input  logic             clk,
    input  logic             arst_n_i,
    input  logic             push_i,
    input  usb_word_t        push_word_i,
    input  logic             pop_i,
    output usb_word_t        head_o,
    output logic             full_o,
    output logic             empty_o,
    output logic [FIFO_AW:0] count_o
);

    localparam int DEPTH = 1 << FIFO_AW;

    usb_word_t          mem_q [DEPTH];
    logic [FIFO_AW-1:0] wr_ptr_q, rd_ptr_q;   // Wrap by overflow
    logic [FIFO_AW:0]   count_q;
    logic [FIFO_AW:0]   count_nxt;

    // Occupancy after this cycle's push and pop
    assign count_nxt = count_q + (FIFO_AW+1)'(push_i) - (FIFO_AW+1)'(pop_i);

    always_ff @(posedge clk) begin
        if (push_i) mem_q[wr_ptr_q] <= push_word_i;
    end

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
            count_q  <= '0;
        end else begin
            if (push_i) wr_ptr_q <= wr_ptr_q + 1'b1;
            if (pop_i)  rd_ptr_q <= rd_ptr_q + 1'b1;
            count_q <= count_nxt;   // Push with pop leaves it unchanged
        end
    end

    assign head_o  = mem_q[rd_ptr_q];   // Show-ahead head word
    assign empty_o = (count_q == '0);
    assign count_o = count_q;

    // Full looks one cycle ahead, since the source's push is registered
    assign full_o = (count_nxt == (FIFO_AW+1)'(DEPTH));

endmodule

// File: verilog/usb_word_source.sv
module usb_word_source import r24_stream_pkg::*; (
    input  logic        clk,
    input  logic        arst_n_i,
    input  wr_src_e     mode_i,
    input  usb_word_t   reg_word_i,
    input  logic        reg_stb_i,
    input  adc_sample_t adc_a_i,
    input  logic        fifo_full_i,   // Already counts the push in flight
    output logic        push_o,
    output usb_word_t   push_word_o,
    output logic        drop_o
);

    logic      cand_vld;   // A word is wanted this cycle
    usb_word_t cand_word;

    // Candidate from the source mode
    always_comb begin
        cand_vld  = 1'b0;
        cand_word = reg_word_i;
        case (mode_i)
            SRC_REG:   cand_vld = reg_stb_i;  // Only on a data write
            SRC_ADC_A: begin
                cand_vld       = 1'b1;         // Every cycle
                cand_word.data = 32'(adc_a_i);
                cand_word.be   = 4'hF;
            end
            default:   cand_vld = 1'b0;       // Idle and code 3
        endcase
    end

    // Payload follows the candidate
    always_ff @(posedge clk) begin
        push_word_o <= cand_word;
    end

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            push_o <= 1'b0;
            drop_o <= 1'b0;
        end else begin
            push_o <= cand_vld && !fifo_full_i;
            drop_o <= cand_vld && fifo_full_i;  // Lost word
        end
    end

endmodule

// File: verilog/stream_regs.sv
module stream_regs import r24_stream_pkg::*; #(
    parameter int FIFO_AW   = 3,
    parameter int LED_DEPTH = 16
) (
    input  logic                 clk,
    input  logic                 arst_n_i,
    input  apb_req_t             apb_i,
    output logic [31:0]          prdata_o,
    input  logic                 fifo_full_i,
    input  logic                 fifo_empty_i,
    input  logic [FIFO_AW:0]     fifo_count_i,
    input  logic                 drop_i,        // One-cycle pulse from the source
    output usb_word_t            reg_word_o,
    output logic                 reg_stb_o,
    output wr_src_e              mode_o,
    output logic [LED_DEPTH-1:0] led0_level_o,
    output logic [LED_DEPTH-1:0] led1_level_o
);

    //////////////////////////////////////////////////
    // Address decode
    //////////////////////////////////////////////////

    logic        page_hit;
    logic        wr_acc;
    logic [11:0] offset;

    assign page_hit = apb_i.psel && (apb_i.paddr[31:12] == REGS_PAGE);
    assign wr_acc   = page_hit && apb_i.penable && apb_i.pwrite;  // Access cycle only
    assign offset   = apb_i.paddr[11:0];

    //////////////////////////////////////////////////
    // Register file
    //////////////////////////////////////////////////

    logic [31:0]          wr_data_q;    // Last software word
    logic [3:0]           wr_be_q;
    wr_src_e              mode_q;
    logic [LED_DEPTH-1:0] led0_q, led1_q;
    logic                 stb_q;
    logic                 drop_q;       // Sticky

    always_ff @(posedge clk) begin
        if (wr_acc && offset == REG_WR_DATA) wr_data_q <= apb_i.pwdata;
    end

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            wr_be_q <= 4'hF;
            mode_q  <= SRC_IDLE;
            led0_q  <= '0;
            led1_q  <= '0;
            stb_q   <= 1'b0;
            drop_q  <= 1'b0;
        end else begin
            stb_q <= wr_acc && (offset == REG_WR_DATA); // Word valid from next cycle
            if (wr_acc) begin
                case (offset)
                    REG_WR_BE:  wr_be_q <= apb_i.pwdata[3:0];
                    REG_WR_MUX: mode_q  <= wr_src_e'(apb_i.pwdata[1:0]);
                    REG_LED0:   led0_q  <= apb_i.pwdata[LED_DEPTH-1:0];
                    REG_LED1:   led1_q  <= apb_i.pwdata[LED_DEPTH-1:0];
                    default: ;
                endcase
            end
            // New drop wins over a clear in the same cycle
            if (drop_i)
                drop_q <= 1'b1;
            else if (wr_acc && offset == REG_STATUS)
                drop_q <= 1'b0;
        end
    end

    assign reg_word_o   = '{data: wr_data_q, be: wr_be_q};
    assign reg_stb_o    = stb_q;
    assign mode_o       = mode_q;
    assign led0_level_o = led0_q;
    assign led1_level_o = led1_q;

    // Read mux gives zero off the page
    always_comb begin
        prdata_o = '0;
        if (page_hit && !apb_i.pwrite) begin
            case (offset)
                REG_WR_DATA: prdata_o = wr_data_q;
                REG_WR_BE:   prdata_o = 32'(wr_be_q);
                REG_WR_MUX:  prdata_o = 32'(mode_q);
                REG_LED0:    prdata_o = 32'(led0_q);
                REG_LED1:    prdata_o = 32'(led1_q);
                REG_STATUS:  prdata_o = {16'd0, 8'(fifo_count_i), 5'd0,
                                         drop_q, fifo_full_i, fifo_empty_i};
                default:     prdata_o = '0;
            endcase
        end
    end

endmodule

// File: verilog/r24_usb_stream_top.sv
module r24_usb_stream_top import r24_stream_pkg::*; #(
    parameter int FIFO_AW   = 3,    // 8 words
    parameter int LED_DEPTH = 16
) (
    input  logic        clk,
    input  logic        arst_n_i,
    input  apb_req_t    apb_i,
    output logic [31:0] prdata_o,
    input  adc_sample_t adc_a_i,
    input  logic        usb_txe_n_i,
    output logic [31:0] usb_d_o,
    output logic [3:0]  usb_be_o,
    output logic        usb_wr_n_o,
    output logic        led0_o,
    output logic        led1_o
);

    // Registers to source
    usb_word_t reg_word;
    logic      reg_stb;
    wr_src_e   mode;
    logic [LED_DEPTH-1:0] led0_level, led1_level;

    // Source to FIFO
    logic      push, drop;
    usb_word_t push_word;

    // FIFO to FT601 side
    usb_word_t head;
    logic      pop, fifo_full, fifo_empty;
    logic [FIFO_AW:0] fifo_count;

    stream_regs #(.FIFO_AW(FIFO_AW), .LED_DEPTH(LED_DEPTH)) stream_regs_inst (
        .clk(clk), .arst_n_i(arst_n_i),
        .apb_i(apb_i), .prdata_o(prdata_o),
        .fifo_full_i(fifo_full), .fifo_empty_i(fifo_empty),
        .fifo_count_i(fifo_count), .drop_i(drop),
        .reg_word_o(reg_word), .reg_stb_o(reg_stb), .mode_o(mode),
        .led0_level_o(led0_level), .led1_level_o(led1_level)
    );

    usb_word_source usb_word_source_inst (
        .clk(clk), .arst_n_i(arst_n_i),
        .mode_i(mode), .reg_word_i(reg_word), .reg_stb_i(reg_stb),
        .adc_a_i(adc_a_i), .fifo_full_i(fifo_full),
        .push_o(push), .push_word_o(push_word), .drop_o(drop)
    );

    usb_word_fifo #(.FIFO_AW(FIFO_AW)) usb_word_fifo_inst (
        .clk(clk), .arst_n_i(arst_n_i),
        .push_i(push), .push_word_i(push_word), .pop_i(pop),
        .head_o(head), .full_o(fifo_full), .empty_o(fifo_empty), .count_o(fifo_count)
    );

    ft601_tx ft601_tx_inst (
        .clk(clk), .arst_n_i(arst_n_i),
        .usb_txe_n_i(usb_txe_n_i), .head_i(head), .empty_i(fifo_empty), .pop_o(pop),
        .usb_d_o(usb_d_o), .usb_be_o(usb_be_o), .usb_wr_n_o(usb_wr_n_o)
    );

    led_ddac #(.LED_DEPTH(LED_DEPTH)) led0_ddac_inst (
        .clk(clk), .arst_n_i(arst_n_i), .level_i(led0_level), .pulse_o(led0_o)
    );

    led_ddac #(.LED_DEPTH(LED_DEPTH)) led1_ddac_inst (
        .clk(clk), .arst_n_i(arst_n_i), .level_i(led1_level), .pulse_o(led1_o)
    );

endmodule

// File: sim/r24_usb_stream_tb.sv
module r24_usb_stream_tb import r24_stream_pkg::*; ();

    localparam int MAX_CMDS   = 128;
    localparam int WORD_WAIT  = 20;     // Cycles an expected word may take
    localparam int CMD_BUDGET = 20;     // Timeout share per command
    localparam int TO_MARGIN  = 50;     // Reset and drain

    // Test file opcodes
    localparam logic [31:0] OP_END    = 32'd0;
    localparam logic [31:0] OP_WRITE  = 32'd1;
    localparam logic [31:0] OP_READ   = 32'd2;
    localparam logic [31:0] OP_TXE    = 32'd3;
    localparam logic [31:0] OP_ADC    = 32'd4;
    localparam logic [31:0] OP_WORD   = 32'd5;
    localparam logic [31:0] OP_WAIT   = 32'd6;
    localparam logic [31:0] OP_LED0   = 32'd7;
    localparam logic [31:0] OP_QUIET  = 32'd8;
    localparam logic [31:0] OP_STREAM = 32'd9;

    logic        clk;
    logic        arst_n;
    apb_req_t    apb;
    logic [31:0] prdata;
    adc_sample_t adc_a = '0;
    logic        usb_txe_n;
    logic [31:0] usb_d;
    logic [3:0]  usb_be;
    logic        usb_wr_n;
    logic        led0;
    logic        led1;

    logic        adc_run;
    adc_sample_t adc_seed;
    logic [31:0] cmd_mem [4*MAX_CMDS];  // Four words per command
    usb_word_t   rx_q [$];              // Words seen on the bus
    int          mismatch_cnt = 0;
    int          fail_cnt = 0;
    int          cycle_cnt = 0;
    int          cycle_limit;

    r24_usb_stream_top #(.FIFO_AW(3), .LED_DEPTH(16)) r24_usb_stream_top_inst (
        .clk(clk), .arst_n_i(arst_n), .apb_i(apb), .prdata_o(prdata),
        .adc_a_i(adc_a), .usb_txe_n_i(usb_txe_n), .usb_d_o(usb_d), .usb_be_o(usb_be),
        .usb_wr_n_o(usb_wr_n), .led0_o(led0), .led1_o(led1)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    //////////////////////////////////////////////////
    // ADC counter, bus monitor, timeout
    //////////////////////////////////////////////////

    always @(posedge clk) begin
        if (adc_run) adc_a <= adc_a + 8'd1;   // Wraps at 256
        else adc_a <= adc_seed;
    end

    // Bus is stable mid-cycle
    always @(negedge clk) begin
        if (arst_n && !usb_wr_n) rx_q.push_back('{data: usb_d, be: usb_be});
    end

    always @(posedge clk) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt == cycle_limit) begin
            $display("ERROR: timeout after %0d cycles, the test sequence did not finish",
                     cycle_cnt);
            $display("Errors: %0d mismatches, %0d other", mismatch_cnt, fail_cnt);
            $display("test failed");
            $finish;
        end
    end

    //////////////////////////////////////////////////
    // Check and bus tasks
    //////////////////////////////////////////////////

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        if (got !== exp) begin
            $display("MISMATCH %s: got 0x%h, expected 0x%h", name, got, exp);
            mismatch_cnt++;
        end
    endtask

    task automatic apb_write(input logic [31:0] addr, input logic [31:0] wdata);
        @(posedge clk);
        apb <= '{paddr: addr, psel: 1'b1, penable: 1'b0, pwrite: 1'b1, pwdata: wdata};
        @(posedge clk);
        apb.penable <= 1'b1;    // Access cycle
        @(posedge clk);
        apb <= '0;
    endtask

    task automatic apb_read(input logic [31:0] addr, output logic [31:0] rdata);
        @(posedge clk);
        apb <= '{paddr: addr, psel: 1'b1, penable: 1'b0, pwrite: 1'b0, pwdata: '0};
        @(posedge clk);
        apb.penable <= 1'b1;
        @(negedge clk);
        rdata = prdata;         // Combinational in the access cycle
        @(posedge clk);
        apb <= '0;
    endtask

    task automatic expect_word(input logic [31:0] exp_data, input logic [3:0] exp_be);
        int        waited;
        usb_word_t got;
        waited = 0;
        while (rx_q.size() == 0 && waited < WORD_WAIT) begin
            @(posedge clk);
            waited++;
        end
        if (rx_q.size() == 0) begin
            $display("ERROR: expected USB word 0x%h never appeared on the bus", exp_data);
            fail_cnt++;
        end else begin
            got = rx_q.pop_front();
            check_value("usb_d_o", got.data, exp_data);
            check_value("usb_be_o", 32'(got.be), 32'(exp_be));
        end
    endtask

    // Each ADC word is the previous one plus one
    task automatic check_adc_stream(input int min_words);
        usb_word_t  got;
        logic [7:0] prev;
        int         n;
        n = 0;
        prev = '0;
        if (rx_q.size() < min_words) begin
            $display("ERROR: only %0d ADC words seen, at least %0d wanted",
                     rx_q.size(), min_words);
            fail_cnt++;
        end
        while (rx_q.size() > 0) begin
            got = rx_q.pop_front();
            if (n > 0) check_value("usb_d_o", got.data, {24'd0, prev + 8'd1});
            else check_value("usb_d_o", got.data, {24'd0, got.data[7:0]});  // Upper zero
            check_value("usb_be_o", 32'(got.be), 32'hF);
            prev = got.data[7:0];
            n++;
        end
    endtask

    task automatic count_led0(input int window, input logic [31:0] exp_cnt);
        int highs;
        highs = 0;
        repeat (window) begin
            @(negedge clk);
            if (led0) highs++;
        end
        check_value("led0_o high count", 32'(highs), exp_cnt);
    endtask

    task automatic run_command(input logic [31:0] op, input logic [31:0] addr,
                               input logic [31:0] data, input logic [31:0] exp);
        logic [31:0] rd;
        case (op)
            OP_WRITE: for (int i = 0; i < ((exp == 0) ? 1 : int'(exp)); i++)
                apb_write(addr, data + 32'(i));
            OP_READ: begin
                apb_read(addr, rd);
                check_value($sformatf("prdata_o at 0x%h", addr), rd, exp);
            end
            OP_TXE: begin
                @(posedge clk);
                usb_txe_n <= data[0];
            end
            OP_ADC: begin
                @(posedge clk);
                adc_seed <= data[7:0];  // Loaded while stopped
                @(posedge clk);
                adc_run <= addr[0];
            end
            OP_WORD: for (int i = 0; i < ((addr == 0) ? 1 : int'(addr)); i++)
                expect_word(data + 32'(i), exp[3:0]);
            OP_WAIT: repeat (data) @(posedge clk);
            OP_LED0: count_led0(int'(data), exp);
            OP_QUIET: begin
                repeat (data) @(posedge clk);
                if (rx_q.size() != 0) begin
                    $display("ERROR: %0d USB words appeared where none were expected",
                             rx_q.size());
                    fail_cnt++;
                    rx_q.delete();
                end
            end
            OP_STREAM: check_adc_stream(int'(data));
            default: begin
                $display("ERROR: unknown opcode 0x%h in the test file", op);
                fail_cnt++;
            end
        endcase
    endtask

    //////////////////////////////////////////////////
    // Main sequence
    //////////////////////////////////////////////////

    initial begin
        int idx;
        apb = '0;
        usb_txe_n = 1'b0;
        adc_run = 1'b0;
        adc_seed = '0;
        arst_n = 1'b0;
        foreach (cmd_mem[i]) cmd_mem[i] = '0;
        $readmemh("sim/stream_tests.hex", cmd_mem);

        // Limit from command count and wait lengths
        cycle_limit = TO_MARGIN;
        idx = 0;
        while (idx < MAX_CMDS && cmd_mem[4*idx] != OP_END) begin
            cycle_limit += CMD_BUDGET;
            if (cmd_mem[4*idx] inside {OP_WAIT, OP_LED0, OP_QUIET})
                cycle_limit += int'(cmd_mem[4*idx+2]);
            idx++;
        end

        repeat (4) @(posedge clk);
        arst_n <= 1'b1;
        @(negedge clk);
        check_value("usb_wr_n_o", 32'(usb_wr_n), 32'd1);   // Idle bus after reset
        check_value("usb_d_o", usb_d, 32'd0);
        check_value("usb_be_o", 32'(usb_be), 32'd0);
        check_value("led0_o", 32'(led0), 32'd0);
        check_value("led1_o", 32'(led1), 32'd0);

        idx = 0;
        while (idx < MAX_CMDS && cmd_mem[4*idx] != OP_END) begin
            run_command(cmd_mem[4*idx], cmd_mem[4*idx+1], cmd_mem[4*idx+2], cmd_mem[4*idx+3]);
            idx++;
        end

        $display("Errors: %0d mismatches, %0d other", mismatch_cnt, fail_cnt);
        if (mismatch_cnt == 0 && fail_cnt == 0) begin
            $display("test passed");
        end else begin
            $display("test failed");
        end
        $finish;
    end

endmodule

// File: r24_usb_stream.f
verilog/r24_stream_pkg.sv
verilog/led_ddac.sv
verilog/ft601_tx.sv
verilog/usb_word_fifo.sv
verilog/usb_word_source.sv
verilog/stream_regs.sv
verilog/r24_usb_stream_top.sv
sim/r24_usb_stream_tb.sv

// File: Makefile
# Verilator build and run of the USB stream testbench
VERILATOR ?= verilator
TOP       ?= r24_usb_stream_tb
FILELIST  ?= r24_usb_stream.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing -j 0

SOURCES := $(shell cat $(FILELIST))
BIN     := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: $(BIN)

# Rebuilt only when a source or the file list changes
$(BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

# Status comes from the search for the pass line
run: $(BIN)
	@out="$$(./$(BIN))"; echo "$$out"; echo "$$out" | grep -qx 'test passed'

clean:
	rm -rf $(OBJ_DIR)

// File: sim/stream_tests.hex
// opcode address data expected; 1 write (expected = repeat, data +1 each), 2 read
// 3 txe_n, 4 adc run/seed, 5 word (address = repeat), 6 wait, 7 led0 window/count
// 8 quiet cycles, 9 adc stream minimum words, 0 end
// Reset state and idle mode
02 43C04014 00000000 00000001
02 43C04008 00000000 00000001
02 43C04004 00000000 0000000F
08 00000000 00000014 00000000
// Register mode, words in write order
01 43C04008 00000000 00000000
01 43C04004 00000003 00000000
01 43C04000 11223344 00000000
01 43C04000 CAFEF00D 00000000
01 43C04004 0000000F 00000000
01 43C04000 A5A5A5A5 00000000
05 00000000 11223344 00000003
05 00000000 CAFEF00D 00000003
05 00000000 A5A5A5A5 0000000F
// Back-pressure, ten words into eight slots
03 00000000 00000001 00000000
01 43C04000 00000100 0000000A
02 43C04014 00000000 00000806
03 00000000 00000000 00000000
05 00000008 00000100 0000000F
08 00000000 0000000A 00000000
01 43C04014 00000000 00000000
02 43C04014 00000000 00000001
// ADC stream across the 8-bit wrap
04 00000001 000000F0 00000000
01 43C04008 00000002 00000000
06 00000000 00000028 00000000
01 43C04008 00000001 00000000
06 00000000 0000000A 00000000
04 00000000 00000000 00000000
09 00000000 00000020 00000000
// LED0 at quarter scale, then off
01 43C0400C 00004000 00000000
06 00000000 00000004 00000000
07 00000000 00000040 00000010
07 00000000 00000040 00000010
01 43C0400C 00000000 00000000
06 00000000 00000004 00000000
07 00000000 00000040 00000000
// Off-page reads and writes
02 43C05008 00000000 00000000
02 00000008 00000000 00000000
01 43C04010 00000055 00000000
01 43C05008 00000000 00000000
01 43C0500C 00001234 00000000
02 43C04008 00000000 00000001
02 43C0400C 00000000 00000000
02 43C04010 00000000 00000055
08 00000000 00000014 00000000
00 00000000 00000000 00000000
